//--- verilog/core_pkg.sv
// ----------------------------------------------------------
// Shared types and constants for the radio core control block.
// Holds the settings bus format, register map and readback
// codes. Modules reference these by scoped name.
// ----------------------------------------------------------

package core_pkg;

   // ----------------------------------------------------------
   // Widths with a meaning
   // ----------------------------------------------------------
   // Settings register address
   typedef logic [7:0]  set_addr_t;
   // Settings write data
   typedef logic [31:0] set_data_t;
   // One complex sample, I and Q packed
   typedef logic [31:0] sample_t;
   // IO delay tap count
   typedef logic [4:0]  delay_t;
   // Readback word select
   typedef logic [2:0]  rb_sel_t;
   // Readback word
   typedef logic [63:0] rb_data_t;
   // SPI chip enables, active low
   typedef logic [7:0]  sen_t;

   // Settings bus, one write per cycle with stb high
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   // ----------------------------------------------------------
   // Register map
   // ----------------------------------------------------------
   // SPI block uses base+0 divider, base+1 control, base+2 data/go
   localparam set_addr_t SR_CORE_SPI           = 8'd8;
   localparam set_addr_t SR_CORE_MISC          = 8'd16;
   localparam set_addr_t SR_CORE_DATA_DELAY    = 8'd17;
   localparam set_addr_t SR_CORE_CLK_DELAY     = 8'd18;
   localparam set_addr_t SR_CORE_RADIO_CONTROL = 8'd19;
   localparam set_addr_t SR_CORE_READBACK      = 8'd20;
   localparam set_addr_t SR_CORE_GPSDO_ST      = 8'd21;
   localparam set_addr_t SR_CORE_PPS_SEL       = 8'd22;
   localparam set_addr_t SR_CORE_LOOPBACK      = 8'd23;

   // Readback select codes
   localparam rb_sel_t RB_CORE_SIGNATURE = 3'd0;
   localparam rb_sel_t RB_CORE_SPI       = 3'd1;
   localparam rb_sel_t RB_CORE_STATUS    = 3'd2;
   localparam rb_sel_t RB_CORE_BIST      = 3'd3;

   // Signature word fields
   localparam logic [31:0] CORE_SIGNATURE = 32'hACE0BA5E;
   localparam logic [15:0] PRODUCT_ID     = 16'd2;
   localparam logic [7:0]  COMPAT_MAJOR   = 8'd1;
   localparam logic [7:0]  COMPAT_MINOR   = 8'd0;

endpackage

//--- verilog/core_settings.sv
// ----------------------------------------------------------
// Core register bank on the settings bus. Decodes the core
// addresses, holds misc, delay, radio control, readback select,
// GPSDO status, PPS select and loopback registers.
// ----------------------------------------------------------
`timescale 1ns/100ps

module core_settings #(
   parameter core_pkg::delay_t CLK_DELAY_AT_RESET = 5'd16
) (
   input  logic                radio_clk,
   input  logic                i_reset,
   // Broadcast settings bus
   input  core_pkg::set_bus_t  i_set,
   // Register outputs
   output core_pkg::set_data_t o_misc,
   output core_pkg::delay_t    o_data_delay,
   output logic                o_ld_data_delay,
   output core_pkg::delay_t    o_clk_delay,
   output logic                o_ld_clk_delay,
   output logic [2:0]          o_radio_control,
   output core_pkg::rb_sel_t   o_rb_sel,
   output logic [7:0]          o_gpsdo_st,
   output logic                o_pps_sel,
   output logic                o_loopback
);

   // ----------------------------------------------------------
   // Address decode
   // ----------------------------------------------------------
   logic wr_misc;
   logic wr_data_delay;
   logic wr_clk_delay;
   logic wr_radio_control;
   logic wr_rb_sel;
   logic wr_gpsdo_st;
   logic wr_pps_sel;
   logic wr_loopback;

   // One strobe per register
   assign wr_misc          = i_set.stb && (i_set.addr == core_pkg::SR_CORE_MISC);
   assign wr_data_delay    = i_set.stb && (i_set.addr == core_pkg::SR_CORE_DATA_DELAY);
   assign wr_clk_delay     = i_set.stb && (i_set.addr == core_pkg::SR_CORE_CLK_DELAY);
   assign wr_radio_control = i_set.stb && (i_set.addr == core_pkg::SR_CORE_RADIO_CONTROL);
   assign wr_rb_sel        = i_set.stb && (i_set.addr == core_pkg::SR_CORE_READBACK);
   assign wr_gpsdo_st      = i_set.stb && (i_set.addr == core_pkg::SR_CORE_GPSDO_ST);
   assign wr_pps_sel       = i_set.stb && (i_set.addr == core_pkg::SR_CORE_PPS_SEL);
   assign wr_loopback      = i_set.stb && (i_set.addr == core_pkg::SR_CORE_LOOPBACK);

   // ----------------------------------------------------------
   // Registers with reset
   // ----------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_misc          <= '0;
         o_data_delay    <= '0;
         o_clk_delay     <= CLK_DELAY_AT_RESET;
         o_radio_control <= '0;
         o_rb_sel        <= core_pkg::RB_CORE_SIGNATURE;
         o_pps_sel       <= 1'b0;
         o_loopback      <= 1'b0;
      end else begin
         if (wr_misc) begin
            o_misc <= i_set.data;
         end
         if (wr_data_delay) begin
            o_data_delay <= i_set.data[4:0];
         end
         if (wr_clk_delay) begin
            o_clk_delay <= i_set.data[4:0];
         end
         if (wr_radio_control) begin
            o_radio_control <= i_set.data[2:0];
         end
         // Only the low select bits are kept
         if (wr_rb_sel) begin
            o_rb_sel <= i_set.data[2:0];
         end
         if (wr_pps_sel) begin
            o_pps_sel <= i_set.data[0];
         end
         if (wr_loopback) begin
            o_loopback <= i_set.data[0];
         end
      end
   end

   // ----------------------------------------------------------
   // Delay load pulses
   // ----------------------------------------------------------
   // High for the single cycle the new delay first shows
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_ld_data_delay <= 1'b0;
         o_ld_clk_delay  <= 1'b0;
      end else begin
         o_ld_data_delay <= wr_data_delay;
         o_ld_clk_delay  <= wr_clk_delay;
      end
   end

   // GPSDO status survives a core reset
   // Host writes it once after the GPSDO reports lock
   always_ff @(posedge radio_clk) begin
      if (wr_gpsdo_st) begin
         o_gpsdo_st <= i_set.data[7:0];
      end
   end

endmodule

//--- verilog/core_spi_master.sv
// ----------------------------------------------------------
// SPI master for peripheral chips, programmed on the settings
// bus. Write divider at base+0, mask and bit count at base+1,
// then data at base+2 to start. Ready returns when done.
// ----------------------------------------------------------
`timescale 1ns/100ps

module core_spi_master #(
   parameter core_pkg::set_addr_t SPI_BASE = 8'd8,
   parameter core_pkg::sen_t      SEN_IDLE = 8'hFF
) (
   input  logic                radio_clk,
   input  logic                i_reset,
   // Broadcast settings bus
   input  core_pkg::set_bus_t  i_set,
   // SPI pins
   output core_pkg::sen_t      o_sen,
   output logic                o_sclk,
   output logic                o_mosi,
   input  logic                i_miso,
   // Status for readback
   output logic                o_spi_ready,
   output core_pkg::set_data_t o_spi_result
);

   typedef enum logic [1:0] {
      IDLE,
      LEAD,
      TRAIL,
      DONE
   } spi_state_t;

   spi_state_t          state;
   // Programmed settings
   logic [15:0]         div_reg;
   logic [5:0]          nbits_reg;
   core_pkg::sen_t      mask_reg;
   // Transfer state
   logic [15:0]         half_cnt;
   logic [5:0]          bits_left;
   core_pkg::set_data_t shift_out;
   logic                half_done;
   logic                go;

   // ----------------------------------------------------------
   // Settings decode
   // ----------------------------------------------------------
   // Data write only starts a transfer when idle
   assign go = i_set.stb && (i_set.addr == SPI_BASE + 8'd2) && o_spi_ready;

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         div_reg   <= '0;
         nbits_reg <= '0;
         mask_reg  <= '0;
      end else if (i_set.stb) begin
         if (i_set.addr == SPI_BASE) begin
            div_reg <= i_set.data[15:0];
         end
         // Control: bit count in [29:24], slave mask in [7:0]
         if (i_set.addr == SPI_BASE + 8'd1) begin
            nbits_reg <= i_set.data[29:24];
            mask_reg  <= i_set.data[7:0];
         end
      end
   end

   // End of an SCLK half period, divider+1 cycles long
   assign half_done = (half_cnt == div_reg);

   // ----------------------------------------------------------
   // Transfer FSM
   // ----------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         state       <= IDLE;
         o_spi_ready <= 1'b1;
         o_sen       <= SEN_IDLE;
         o_sclk      <= 1'b0;
         o_mosi      <= 1'b0;
         half_cnt    <= '0;
         bits_left   <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (go) begin
                  state       <= LEAD;
                  o_spi_ready <= 1'b0;
                  o_sen       <= ~mask_reg;
                  // First bit set up ahead of first rising edge
                  o_mosi      <= i_set.data[31];
                  half_cnt    <= '0;
                  bits_left   <= nbits_reg;
               end
            end
            // SCLK low half
            LEAD: begin
               if (half_done) begin
                  half_cnt <= '0;
                  o_sclk   <= 1'b1;
                  state    <= TRAIL;
               end else begin
                  half_cnt <= half_cnt + 16'd1;
               end
            end
            // SCLK high half, next bit driven at the falling edge
            TRAIL: begin
               if (half_done) begin
                  half_cnt <= '0;
                  o_sclk   <= 1'b0;
                  if (bits_left <= 6'd1) begin
                     state <= DONE;
                  end else begin
                     o_mosi    <= shift_out[30];
                     bits_left <= bits_left - 6'd1;
                     state     <= LEAD;
                  end
               end else begin
                  half_cnt <= half_cnt + 16'd1;
               end
            end
            DONE: begin
               o_sen       <= SEN_IDLE;
               o_mosi      <= 1'b0;
               o_spi_ready <= 1'b1;
               state       <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // Data shifters, MSB out first and MISO into the low end
   always_ff @(posedge radio_clk) begin
      if (state == IDLE && go) begin
         shift_out    <= i_set.data;
         o_spi_result <= '0;
      end else if (state == LEAD && half_done) begin
         o_spi_result <= {o_spi_result[30:0], i_miso};
      end else if (state == TRAIL && half_done) begin
         shift_out <= {shift_out[30:0], 1'b0};
      end
   end

endmodule

//--- verilog/core_readback.sv
// ----------------------------------------------------------
// Readback mux for the core. Picks the 64-bit word named by
// the readback select register; purely combinational.
// ----------------------------------------------------------
`timescale 1ns/100ps

module core_readback (
   input  core_pkg::rb_sel_t   i_rb_sel,
   // Sources
   input  core_pkg::set_data_t i_spi_result,
   input  logic                i_spi_ready,
   input  logic [7:0]          i_gpsdo_st,
   input  logic [31:0]         i_rb_misc,
   input  logic                i_bist_done,
   input  logic                i_bist_error,
   // Selected word
   output core_pkg::rb_data_t  o_rb_data
);

   always_comb begin
      case (i_rb_sel)
         // Identity and compatibility numbers
         core_pkg::RB_CORE_SIGNATURE: begin
            o_rb_data = {core_pkg::CORE_SIGNATURE, core_pkg::PRODUCT_ID,
                         core_pkg::COMPAT_MAJOR, core_pkg::COMPAT_MINOR};
         end
         // Ready flag above last SPI result
         core_pkg::RB_CORE_SPI: begin
            o_rb_data = {31'd0, i_spi_ready, i_spi_result};
         end
         // GPSDO status over board misc inputs
         core_pkg::RB_CORE_STATUS: begin
            o_rb_data = {24'd0, i_gpsdo_st, i_rb_misc};
         end
         // External FIFO BIST flags
         core_pkg::RB_CORE_BIST: begin
            o_rb_data = {62'd0, i_bist_error, i_bist_done};
         end
         default: begin
            o_rb_data = '0;
         end
      endcase
   end

endmodule

//--- verilog/radio_io_sync.sv
// ----------------------------------------------------------
// Radio side glue. Synchronizes both PPS sources and picks one,
// and registers the receive samples with optional loopback of
// the transmit samples per channel.
// ----------------------------------------------------------
`timescale 1ns/100ps

module radio_io_sync (
   input  logic              radio_clk,
   // PPS sources and select
   input  logic              i_pps_int,
   input  logic              i_pps_ext,
   input  logic              i_pps_sel,
   // Loopback enable
   input  logic              i_loopback,
   // Samples
   input  core_pkg::sample_t i_rx0,
   input  core_pkg::sample_t i_rx1,
   input  core_pkg::sample_t i_tx0,
   input  core_pkg::sample_t i_tx1,
   // Outputs
   output logic              o_pps,
   output core_pkg::sample_t o_rx0,
   output core_pkg::sample_t o_rx1
);

   // ----------------------------------------------------------
   // PPS
   // ----------------------------------------------------------
   // Two flop synchronizers, bit 1 is the settled copy
   logic [1:0] pps_int_sync;
   logic [1:0] pps_ext_sync;

   always_ff @(posedge radio_clk) begin
      pps_int_sync <= {pps_int_sync[0], i_pps_int};
      pps_ext_sync <= {pps_ext_sync[0], i_pps_ext};
   end

   // 1 selects the external reference
   assign o_pps = i_pps_sel ? pps_ext_sync[1] : pps_int_sync[1];

   // ----------------------------------------------------------
   // Receive loopback
   // ----------------------------------------------------------
   // Each channel returns its own transmit sample
   always_ff @(posedge radio_clk) begin
      if (i_loopback) begin
         o_rx0 <= i_tx0;
         o_rx1 <= i_tx1;
      end else begin
         o_rx0 <= i_rx0;
         o_rx1 <= i_rx1;
      end
   end

endmodule

//--- verilog/core_ctrl_top.sv
// ----------------------------------------------------------
// Global control top level. Puts the register bank, SPI master,
// readback mux and radio IO glue on one settings bus.
// Parameters set the SPI base, idle chip enables and clock delay.
// ----------------------------------------------------------
`timescale 1ns/100ps

module core_ctrl_top #(
   parameter core_pkg::set_addr_t SPI_BASE           = core_pkg::SR_CORE_SPI,
   parameter core_pkg::sen_t      SEN_IDLE           = 8'hFF,
   parameter core_pkg::delay_t    CLK_DELAY_AT_RESET = 5'd16
) (
   input  logic                radio_clk,
   input  logic                i_reset,
   // Settings bus and board inputs
   input  core_pkg::set_bus_t  i_set,
   input  logic                i_miso,
   input  logic [31:0]         i_rb_misc,
   input  logic                i_bist_done,
   input  logic                i_bist_error,
   input  logic                i_pps_int,
   input  logic                i_pps_ext,
   input  core_pkg::sample_t   i_rx0,
   input  core_pkg::sample_t   i_rx1,
   input  core_pkg::sample_t   i_tx0,
   input  core_pkg::sample_t   i_tx1,
   // Readback and SPI
   output core_pkg::rb_data_t  o_rb_data,
   output logic                o_spi_ready,
   output core_pkg::sen_t      o_sen,
   output logic                o_sclk,
   output logic                o_mosi,
   // Control registers
   output core_pkg::set_data_t o_misc,
   output core_pkg::delay_t    o_data_delay,
   output logic                o_ld_data_delay,
   output core_pkg::delay_t    o_clk_delay,
   output logic                o_ld_clk_delay,
   output logic [2:0]          o_radio_control,
   // Radio side
   output logic                o_pps,
   output core_pkg::sample_t   o_rx0,
   output core_pkg::sample_t   o_rx1
);

   core_pkg::rb_sel_t   rb_sel;
   core_pkg::set_data_t spi_result;
   logic [7:0]          gpsdo_st;
   logic                pps_sel;
   logic                loopback;

   // ----------------------------------------------------------
   // Settings bus peers
   // ----------------------------------------------------------
   core_settings #(.CLK_DELAY_AT_RESET(CLK_DELAY_AT_RESET)) u_settings (
      .radio_clk(radio_clk), .i_reset(i_reset), .i_set(i_set),
      .o_misc(o_misc),
      .o_data_delay(o_data_delay), .o_ld_data_delay(o_ld_data_delay),
      .o_clk_delay(o_clk_delay), .o_ld_clk_delay(o_ld_clk_delay),
      .o_radio_control(o_radio_control), .o_rb_sel(rb_sel),
      .o_gpsdo_st(gpsdo_st), .o_pps_sel(pps_sel), .o_loopback(loopback)
   );

   core_spi_master #(.SPI_BASE(SPI_BASE), .SEN_IDLE(SEN_IDLE)) u_spi (
      .radio_clk(radio_clk), .i_reset(i_reset), .i_set(i_set),
      .o_sen(o_sen), .o_sclk(o_sclk), .o_mosi(o_mosi), .i_miso(i_miso),
      .o_spi_ready(o_spi_ready), .o_spi_result(spi_result)
   );

   // Readback word for the host
   core_readback u_readback (
      .i_rb_sel(rb_sel), .i_spi_result(spi_result), .i_spi_ready(o_spi_ready),
      .i_gpsdo_st(gpsdo_st), .i_rb_misc(i_rb_misc),
      .i_bist_done(i_bist_done), .i_bist_error(i_bist_error),
      .o_rb_data(o_rb_data)
   );

   // PPS select and receive loopback
   radio_io_sync u_io_sync (
      .radio_clk(radio_clk),
      .i_pps_int(i_pps_int), .i_pps_ext(i_pps_ext), .i_pps_sel(pps_sel),
      .i_loopback(loopback),
      .i_rx0(i_rx0), .i_rx1(i_rx1), .i_tx0(i_tx0), .i_tx1(i_tx1),
      .o_pps(o_pps), .o_rx0(o_rx0), .o_rx1(o_rx1)
   );

endmodule

//--- sim/tb_core_ctrl.sv
// ----------------------------------------------------------
// Testbench for the global control top level. Drives the
// settings bus, checks registers, readback, SPI, loopback and
// PPS against a model kept here. Run through tb.f.
// ----------------------------------------------------------
`timescale 1ns/100ps

module tb_core_ctrl;

   // Test lengths that also set the run limit
   localparam int N_REG   = 24;
   localparam int N_RB    = 16;
   localparam int N_SPI   = 8;
   localparam int MAX_DIV = 3;
   localparam int N_LOOP  = 16;
   localparam int MAX_CYCLES = 16 + N_REG * 6 + N_RB * 3
                             + N_SPI * (64 * (MAX_DIV + 1) + 16) + N_LOOP * 3 + 300;

   // DUT ports
   logic                radio_clk;
   logic                i_reset;
   core_pkg::set_bus_t  i_set;
   logic                i_miso;
   logic [31:0]         i_rb_misc;
   logic                i_bist_done;
   logic                i_bist_error;
   logic                i_pps_int;
   logic                i_pps_ext;
   core_pkg::sample_t   i_rx0;
   core_pkg::sample_t   i_rx1;
   core_pkg::sample_t   i_tx0;
   core_pkg::sample_t   i_tx1;
   core_pkg::rb_data_t  o_rb_data;
   logic                o_spi_ready;
   core_pkg::sen_t      o_sen;
   logic                o_sclk;
   logic                o_mosi;
   core_pkg::set_data_t o_misc;
   core_pkg::delay_t    o_data_delay;
   logic                o_ld_data_delay;
   core_pkg::delay_t    o_clk_delay;
   logic                o_ld_clk_delay;
   logic [2:0]          o_radio_control;
   logic                o_pps;
   core_pkg::sample_t   o_rx0;
   core_pkg::sample_t   o_rx1;

   // Model of the state behind the readback word
   core_pkg::rb_sel_t   m_rb_sel;
   logic [7:0]          m_gpsdo;
   core_pkg::set_data_t m_spi_result;
   logic                m_spi_ready;
   logic                rb_check_en = 1'b0;

   // Bookkeeping and stimulus scratch
   string               test_name = "reset";
   int                  check_count = 0;
   int                  error_count = 0;
   int                  cycle_cnt = 0;
   integer              seed;
   logic [31:0]         rnd;
   logic [31:0]         rnd2;
   logic [5:0]          nbits;
   core_pkg::sen_t      mask;
   core_pkg::sample_t   exp_rx0;
   core_pkg::sample_t   exp_rx1;
   core_pkg::rb_sel_t   sel_list [4];
   // SCLK activity seen during one transfer
   int                  sclk_rises;
   int                  sclk_high;
   logic                sclk_prev;

   // MISO looped back from MOSI
   assign i_miso = o_mosi;

   core_ctrl_top #(
      .SPI_BASE(core_pkg::SR_CORE_SPI),
      .SEN_IDLE(8'hFF),
      .CLK_DELAY_AT_RESET(5'd16)
   ) i_dut (.*);

   // 4 ns clock
   always #2 radio_clk = ~radio_clk;

   // Run limit from the test lengths
   always @(posedge radio_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // ----------------------------------------------------------
   // Reference model and compare tasks
   // ----------------------------------------------------------
   // Readback word as the register map defines it
   function automatic core_pkg::rb_data_t rb_ref(input core_pkg::rb_sel_t sel,
         input logic [7:0] gpsdo, input core_pkg::set_data_t spi_res,
         input logic spi_rdy, input logic [31:0] misc, input logic done, input logic err);
      core_pkg::rb_data_t word;
      case (sel)
         3'd0: word = 64'hACE0_BA5E_0002_0100;
         3'd1: word = {31'd0, spi_rdy, spi_res};
         3'd2: word = {24'd0, gpsdo, misc};
         3'd3: word = {62'd0, err, done};
         default: word = '0;
      endcase
      return word;
   endfunction

   // Model state plus the live board inputs
   function automatic core_pkg::rb_data_t rb_expected();
      return rb_ref(m_rb_sel, m_gpsdo, m_spi_result, m_spi_ready, i_rb_misc,
                    i_bist_done, i_bist_error);
   endfunction

   task automatic check_rb(input string name, input core_pkg::rb_data_t exp,
         input core_pkg::rb_data_t act);
      check_count++;
      if (act !== exp) begin
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
         error_count++;
      end
   endtask

   task automatic check_sample(input string name, input core_pkg::sample_t exp,
         input core_pkg::sample_t act);
      check_count++;
      if (act !== exp) begin
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
         error_count++;
      end
   endtask

   task automatic check_delay(input string name, input core_pkg::delay_t exp,
         input core_pkg::delay_t act);
      check_count++;
      if (act !== exp) begin
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
         error_count++;
      end
   endtask

   task automatic check_data(input string name, input core_pkg::set_data_t exp,
         input core_pkg::set_data_t act);
      check_count++;
      if (act !== exp) begin
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
         error_count++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      check_count++;
      if (act !== exp) begin
         $display("FAILED %s: expected %b, actual %b", name, exp, act);
         error_count++;
      end
   endtask

   // Readback watched at every falling edge
   always @(negedge radio_clk) begin
      if (rb_check_en) begin
         check_rb(test_name, rb_expected(), o_rb_data);
      end
   end

   // ----------------------------------------------------------
   // Bus helpers
   // ----------------------------------------------------------
   // Step to just after the next rising edge
   task automatic tick();
      @(posedge radio_clk);
      #1;
   endtask

   // One settings write that returns with the new value visible
   task automatic set_write(input core_pkg::set_addr_t addr, input core_pkg::set_data_t data);
      i_set.stb  = 1'b1;
      i_set.addr = addr;
      i_set.data = data;
      tick();
      i_set.stb = 1'b0;
      if (addr == core_pkg::SR_CORE_READBACK) begin
         m_rb_sel = data[2:0];
      end
      if (addr == core_pkg::SR_CORE_GPSDO_ST) begin
         m_gpsdo = data[7:0];
      end
   endtask

   // ----------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------
   initial begin
      seed = 56;
      radio_clk = 1'b0;
      i_reset = 1'b1;
      i_set = '0;
      i_rb_misc = '0;
      i_bist_done = 1'b0;
      i_bist_error = 1'b0;
      i_pps_int = 1'b0;
      i_pps_ext = 1'b0;
      i_rx0 = '0;
      i_rx1 = '0;
      i_tx0 = '0;
      i_tx1 = '0;
      m_rb_sel = 3'd0;
      m_spi_ready = 1'b1;
      sel_list = '{core_pkg::RB_CORE_STATUS, core_pkg::RB_CORE_BIST, 3'd6, 3'd7};
      repeat (16) @(posedge radio_clk);
      #1;
      i_reset = 1'b0;

      // Reset values
      check_delay(test_name, 5'd0, o_data_delay);
      check_delay(test_name, 5'd16, o_clk_delay);
      check_bit(test_name, 1'b0, o_ld_data_delay);
      check_bit(test_name, 1'b0, o_ld_clk_delay);
      check_data(test_name, 32'd0, o_misc);
      check_data(test_name, 32'd0, {29'd0, o_radio_control});
      check_bit(test_name, 1'b1, o_spi_ready);
      check_data(test_name, 32'h0000_00FF, {24'd0, o_sen});
      check_bit(test_name, 1'b0, o_sclk);
      check_bit(test_name, 1'b0, o_mosi);
      check_rb(test_name, 64'hACE0_BA5E_0002_0100, o_rb_data);
      rb_check_en = 1'b1;

      // Back to back register writes so each load pulse must drop
      test_name = "register writes";
      for (int k = 0; k < N_REG; k++) begin
         rnd = $random(seed);
         set_write(core_pkg::SR_CORE_MISC, rnd);
         check_data(test_name, rnd, o_misc);
         rnd = $random(seed);
         set_write(core_pkg::SR_CORE_DATA_DELAY, rnd);
         check_delay(test_name, rnd[4:0], o_data_delay);
         check_bit(test_name, 1'b1, o_ld_data_delay);
         check_bit(test_name, 1'b0, o_ld_clk_delay);
         rnd2 = $random(seed);
         set_write(core_pkg::SR_CORE_CLK_DELAY, rnd2);
         check_delay(test_name, rnd2[4:0], o_clk_delay);
         check_bit(test_name, 1'b1, o_ld_clk_delay);
         check_bit(test_name, 1'b0, o_ld_data_delay);
         rnd = $random(seed);
         set_write(core_pkg::SR_CORE_RADIO_CONTROL, rnd);
         check_data(test_name, {29'd0, rnd[2:0]}, {29'd0, o_radio_control});
         check_bit(test_name, 1'b0, o_ld_clk_delay);
         check_delay(test_name, rnd2[4:0], o_clk_delay);
      end

      // Readback select with live board inputs
      test_name = "readback select";
      rnd = $random(seed);
      set_write(core_pkg::SR_CORE_GPSDO_ST, rnd);
      for (int k = 0; k < N_RB; k++) begin
         rnd = $random(seed);
         i_rb_misc = $random(seed);
         i_bist_done = rnd[0];
         i_bist_error = rnd[1];
         set_write(core_pkg::SR_CORE_READBACK, {rnd[31:3], sel_list[k[1:0]]});
         check_rb(test_name, rb_expected(), o_rb_data);
         i_rb_misc = $random(seed);
         tick();
         check_rb(test_name, rb_expected(), o_rb_data);
      end

      // SPI with MOSI wrapped to MISO
      test_name = "spi transfer";
      for (int k = 0; k < N_SPI; k++) begin
         rnd = $random(seed);
         rnd2 = $random(seed);
         nbits = {1'b0, rnd[8:4]} + 6'd1;
         mask = rnd[23:16];
         set_write(core_pkg::SR_CORE_SPI, {30'd0, rnd[1:0]});
         set_write(core_pkg::SR_CORE_SPI + 8'd1, {2'b00, nbits, 16'd0, mask});
         rb_check_en = 1'b0;
         set_write(core_pkg::SR_CORE_SPI + 8'd2, rnd2);
         check_bit(test_name, 1'b0, o_spi_ready);
         sclk_rises = 0;
         sclk_high  = 0;
         sclk_prev  = 1'b0;
         while (o_spi_ready !== 1'b1) begin
            check_data(test_name, {24'd0, ~mask}, {24'd0, o_sen});
            // One rising SCLK edge per bit
            if (o_sclk === 1'b1) begin
               sclk_high++;
               if (sclk_prev !== 1'b1) begin
                  sclk_rises++;
               end
            end
            sclk_prev = o_sclk;
            tick();
         end
         check_data(test_name, 32'h0000_00FF, {24'd0, o_sen});
         check_bit(test_name, 1'b0, o_sclk);
         // Each high half lasts divider+1 cycles
         check_data(test_name, 32'(nbits), sclk_rises);
         check_data(test_name, 32'(nbits) * (32'(rnd[1:0]) + 32'd1), sclk_high);
         // Looped bits come back as the top bits of the word
         m_spi_result = rnd2 >> (6'd32 - nbits);
         m_spi_ready = 1'b1;
         set_write(core_pkg::SR_CORE_READBACK, {29'd0, core_pkg::RB_CORE_SPI});
         check_rb(test_name, rb_expected(), o_rb_data);
         rb_check_en = 1'b1;
      end

      // Loopback off, then on
      test_name = "loopback";
      for (int lb = 0; lb < 2; lb++) begin
         set_write(core_pkg::SR_CORE_LOOPBACK, {31'd0, lb[0]});
         for (int k = 0; k < N_LOOP; k++) begin
            i_rx0 = $random(seed);
            i_rx1 = $random(seed);
            i_tx0 = $random(seed);
            i_tx1 = $random(seed);
            exp_rx0 = lb[0] ? i_tx0 : i_rx0;
            exp_rx1 = lb[0] ? i_tx1 : i_rx1;
            tick();
            check_sample(test_name, exp_rx0, o_rx0);
            check_sample(test_name, exp_rx1, o_rx1);
         end
      end

      // One pulse per source under each select
      test_name = "pps select";
      for (int sel = 0; sel < 2; sel++) begin
         set_write(core_pkg::SR_CORE_PPS_SEL, {31'd0, sel[0]});
         for (int src = 0; src < 2; src++) begin
            i_pps_int = (src == 0);
            i_pps_ext = (src == 1);
            tick();
            i_pps_int = 1'b0;
            i_pps_ext = 1'b0;
            check_bit(test_name, 1'b0, o_pps);
            tick();
            check_bit(test_name, src == sel, o_pps);
            tick();
            check_bit(test_name, 1'b0, o_pps);
         end
      end

      tick();
      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- tb.f
verilog/core_pkg.sv
verilog/core_settings.sv
verilog/core_spi_master.sv
verilog/core_readback.sv
verilog/radio_io_sync.sv
verilog/core_ctrl_top.sv
sim/tb_core_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the control core testbench with Verilator.
# Exit status is nonzero unless the log holds the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps \
   -f tb.f --top-module tb_core_ctrl -Mdir obj_dir

obj_dir/Vtb_core_ctrl > sim.log 2>&1
cat sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see sim.log"
   exit 1
fi
